//--- files.f
+incdir+.
frame_fifo_pkg.sv
frame_fifo_ram.sv
frame_fifo_wr_ctrl.sv
frame_fifo_rd_pipe.sv
frame_fifo.sv
frame_fifo_checker.sv
frame_fifo_tb.sv

//--- frame_fifo.sv
// frame FIFO top that joins write control, beat memory and read pipeline

`default_nettype none

module frame_fifo
    import frame_fifo_pkg::*;
(
    input  wire logic          m_clk,
    input  wire logic          m_rst,

    // input stream
    input  wire logic          s_valid,
    input  wire beat_t         s_beat,
    output logic               s_ready,

    // output stream
    output logic               m_valid,
    output beat_t              m_beat,
    input  wire logic          m_ready,

    // per-frame status and fill level
    output frame_status_t      status,
    output depth_t             status_depth,
    output depth_t             status_depth_commit
);

    logic  wr_en;
    addr_t wr_addr;
    beat_t wr_beat;
    logic  rd_en;
    addr_t rd_addr;
    beat_t rd_beat;
    ptr_t  commit_ptr;
    ptr_t  rd_ptr;

    frame_fifo_wr_ctrl wr_ctrl_i (
        .m_clk               (m_clk),
        .m_rst               (m_rst),
        .s_valid             (s_valid),
        .s_beat              (s_beat),
        .s_ready             (s_ready),
        .rd_ptr              (rd_ptr),
        .wr_en               (wr_en),
        .wr_addr             (wr_addr),
        .wr_beat             (wr_beat),
        .commit_ptr          (commit_ptr),
        .status              (status),
        .status_depth        (status_depth),
        .status_depth_commit (status_depth_commit)
    );

    frame_fifo_ram ram_i (
        .m_clk   (m_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_beat (wr_beat),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_beat (rd_beat)
    );

    frame_fifo_rd_pipe rd_pipe_i (
        .m_clk      (m_clk),
        .m_rst      (m_rst),
        .commit_ptr (commit_ptr),
        .rd_beat    (rd_beat),
        .m_ready    (m_ready),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_ptr     (rd_ptr),
        .m_valid    (m_valid),
        .m_beat     (m_beat)
    );

endmodule

`default_nettype wire

//--- frame_fifo_checker.sv
// frame FIFO protocol checker with concurrent assertions on the top-level ports

`default_nettype none

`include "frame_fifo_defines.svh"

module frame_fifo_checker
    import frame_fifo_pkg::*;
(
    input wire logic          m_clk,
    input wire logic          m_rst,
    input wire logic          s_valid,
    input wire beat_t         s_beat,
    input wire logic          s_ready,
    input wire logic          m_valid,
    input wire beat_t         m_beat,
    input wire logic          m_ready,
    input wire frame_status_t status,
    input wire depth_t        status_depth,
    input wire depth_t        status_depth_commit
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned failures = 0;

    // stalled output beat stays put until taken
    a_out_hold: assert property (@(posedge m_clk) disable iff (m_rst)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
        else begin
            failures++;
            $error("m_valid or m_beat changed while stalled");
        end

    a_reset_quiet: assert property (@(posedge m_clk) m_rst |-> (!s_ready && !m_valid))
        else begin
            failures++;
            $error("s_ready or m_valid high during reset");
        end

    a_depth_max: assert property (@(posedge m_clk) disable iff (m_rst)
        status_depth <= depth_t'(`FF_DEPTH))
        else begin
            failures++;
            $error("status_depth above memory size");
        end

    // committed data is part of all written data
    a_depth_order: assert property (@(posedge m_clk) disable iff (m_rst)
        status_depth >= status_depth_commit)
        else begin
            failures++;
            $error("status_depth below status_depth_commit");
        end

    // a frame outcome always follows an accepted last beat
    a_status_cause: assert property (@(posedge m_clk) disable iff (m_rst)
        (status != '0) |-> $past(s_valid && s_ready && s_beat.last))
        else begin
            failures++;
            $error("status pulse without a last beat");
        end

endmodule

bind frame_fifo frame_fifo_checker chk_i (.*);

`default_nettype wire

//--- frame_fifo_defines.svh
// frame FIFO sizing constants and the bad-frame marker value

`ifndef FRAME_FIFO_DEFINES_SVH
`define FRAME_FIFO_DEFINES_SVH

// memory entries with one beat per entry
`define FF_DEPTH 16

// address bits into the memory as log2 of FF_DEPTH
`define FF_AW 4

// beat payload width
`define FF_DATA_W 32

// user sideband width
`define FF_USER_W 1

// user value on the last beat that marks the frame as bad
`define FF_USER_BAD 1

`endif

//--- frame_fifo_pkg.sv
// frame FIFO types shared by the write, storage and read blocks

`default_nettype none

`include "frame_fifo_defines.svh"

package frame_fifo_pkg;

    typedef logic [`FF_DATA_W-1:0] data_t;
    typedef logic [`FF_USER_W-1:0] user_t;
    typedef logic [`FF_AW-1:0]     addr_t;

    // extra msb tells a full memory from an empty one
    typedef logic [`FF_AW:0]       ptr_t;
    typedef logic [`FF_AW:0]       depth_t;

    // one stream beat that is also the memory word
    typedef struct packed {
        data_t data;
        logic  last;
        user_t user;
    } beat_t;

    // single-cycle per-frame outcome pulses
    typedef struct packed {
        logic good_frame;
        logic bad_frame;
        logic overflow;
    } frame_status_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_FRAME,
        WR_DROP
    } wr_state_e;

endpackage

`default_nettype wire

//--- frame_fifo_ram.sv
// frame FIFO beat memory with one write port and one registered read port

`default_nettype none

`include "frame_fifo_defines.svh"

module frame_fifo_ram
    import frame_fifo_pkg::*;
(
    input  wire logic  m_clk,

    input  wire logic  wr_en,
    input  wire addr_t wr_addr,
    input  wire beat_t wr_beat,

    input  wire logic  rd_en,
    input  wire addr_t rd_addr,
    output beat_t      rd_beat
);

    beat_t mem [`FF_DEPTH];

    always_ff @(posedge m_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // output register holds its word while rd_en is low
    always_ff @(posedge m_clk) begin
        if (rd_en) begin
            rd_beat <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- frame_fifo_rd_pipe.sv
// frame FIFO read side with the read pointer, a RAM stage and an output stage under back-pressure

`default_nettype none

`include "frame_fifo_defines.svh"

module frame_fifo_rd_pipe
    import frame_fifo_pkg::*;
(
    input  wire logic  m_clk,
    input  wire logic  m_rst,

    // committed end of data from the write side
    input  wire ptr_t  commit_ptr,

    // memory read port
    input  wire beat_t rd_beat,
    output logic       rd_en,
    output addr_t      rd_addr,
    output ptr_t       rd_ptr,

    // output stream
    output logic       m_valid,
    output beat_t      m_beat,
    input  wire logic  m_ready
);

    ptr_t  rd_ptr_q;
    logic  ram_valid;
    logic  out_valid;
    beat_t out_beat;

    logic empty;
    logic out_take;
    logic ram_take;

    // only committed frames are visible here
    assign empty = rd_ptr_q == commit_ptr;

    // output stage is free or its beat leaves this cycle
    assign out_take = m_ready || !out_valid;

    // RAM stage is free or moves into the output stage
    assign ram_take = !ram_valid || out_take;

    assign rd_en = !empty && ram_take;
    assign rd_addr = rd_ptr_q[`FF_AW-1:0];
    assign rd_ptr = rd_ptr_q;

    assign m_valid = out_valid;
    assign m_beat = out_beat;

    always_ff @(posedge m_clk or posedge m_rst) begin
        if (m_rst) begin
            rd_ptr_q <= '0;
            ram_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + ptr_t'(1);
            end

            // RAM stage keeps its beat while the output stage stalls
            if (ram_take) begin
                ram_valid <= rd_en;
            end

            if (out_take) begin
                out_valid <= ram_valid;
            end
        end
    end

    // payload follows the valid bit
    always_ff @(posedge m_clk) begin
        if (out_take && ram_valid) begin
            out_beat <= rd_beat;
        end
    end

endmodule

`default_nettype wire

//--- frame_fifo_tb.sv
// frame FIFO testbench that checks random good, bad and oversize frames in order at the output

`default_nettype none

`include "frame_fifo_defines.svh"

module frame_fifo_tb
    import frame_fifo_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_FRAMES = 40;
    localparam int MAX_LEN = 20;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * MAX_LEN * 4 + 200;
    localparam int KIND_GOOD = 0;
    localparam int KIND_BAD = 1;
    localparam int KIND_OVER = 2;

    logic          m_clk = 1'b0;
    logic          m_rst;
    logic          s_valid;
    beat_t         s_beat;
    logic          s_ready;
    logic          m_valid;
    beat_t         m_beat;
    logic          m_ready;
    frame_status_t status;
    depth_t        status_depth;
    depth_t        status_depth_commit;

    int    seed = 77639;
    int    ready_seed = 77639;
    int    ready_pct = 75;
    logic  expect_ready = 1'b0;
    beat_t exp_q[$];
    int    committed_frames = 0;
    int    done_frames = 0;
    int    exp_good = 0;
    int    exp_bad = 0;
    int    exp_over = 0;
    int    seen_good = 0;
    int    seen_bad = 0;
    int    seen_over = 0;
    int    stall_cycles = 0;

    frame_fifo frame_fifo_i (.*);

    always #4 m_clk = ~m_clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    function automatic int frame_kind(input int f);
        if (f == 16 || f == 18 || f == 34) begin
            return KIND_BAD;
        end
        if (f == 20 || f == 28) begin
            return KIND_OVER;
        end
        return KIND_GOOD;
    endfunction

    // starts and ends 1 ns after a rising edge
    task automatic send_beat(input beat_t b);
        logic took;
        s_valid = 1'b1;
        s_beat = b;
        do begin
            @(negedge m_clk);
            took = s_ready;
            if (expect_ready) begin
                assert (s_ready) else report_failure("s_ready fell during an oversize frame");
            end
            @(posedge m_clk);
            #1;
        end while (!took);
        s_valid = 1'b0;
    endtask

    task automatic send_frame(input int len, input int kind);
        beat_t b;
        beat_t frame_q[$];
        expect_ready = (kind == KIND_OVER);
        for (int i = 0; i < len; i++) begin
            if (i > 0 && ({$random(seed)} % 100) < 15) begin
                @(posedge m_clk);
                #1;
            end
            b.data = data_t'($random(seed));
            b.last = (i == len - 1);
            b.user = user_t'($random(seed));
            if (b.last) begin
                b.user = (kind == KIND_BAD) ? user_t'(`FF_USER_BAD) : ~user_t'(`FF_USER_BAD);
            end
            send_beat(b);
            frame_q.push_back(b);
        end
        expect_ready = 1'b0;
        if (kind == KIND_GOOD) begin
            exp_q = {exp_q, frame_q};
            committed_frames++;
            exp_good++;
        end else if (kind == KIND_BAD) begin
            exp_bad++;
        end else begin
            exp_over++;
        end
    endtask

    task automatic wait_drained();
        do begin
            @(negedge m_clk);
        end while (exp_q.size() != 0 || m_valid || status_depth != '0);
        @(posedge m_clk);
        #1;
    endtask

    always begin
        @(posedge m_clk);
        #1;
        m_ready = ({$random(ready_seed)} % 100) < ready_pct;
    end

    // scoreboard samples mid-cycle where every DUT output is settled
    always @(negedge m_clk) begin
        if (!m_rst) begin
            seen_good += int'(status.good_frame);
            seen_bad += int'(status.bad_frame);
            seen_over += int'(status.overflow);
            // a stall with stored data can only come from a full memory
            if (s_valid && !s_ready && status_depth != '0) begin
                stall_cycles++;
            end
            if (m_valid) begin
                assert (committed_frames > done_frames)
                    else report_failure("output beat before its frame was committed");
            end
            if (m_valid && m_ready) begin
                assert (exp_q.size() > 0) else report_failure("output beat with none expected");
                assert (m_beat == exp_q[0]) else report_failure(
                    $sformatf("mismatch m_beat expected %h actual %h", exp_q[0], m_beat));
                void'(exp_q.pop_front());
                if (m_beat.last) begin
                    done_frames++;
                end
            end
            assert (frame_fifo_i.chk_i.failures == 0)
                else report_failure("a checker assertion failed");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge m_clk);
        report_failure("timeout, the FIFO did not drain in time");
    end

    initial begin : stimulus
        int len;
        int kind;
        m_rst = 1'b1;
        s_valid = 1'b0;
        s_beat = '0;
        m_ready = 1'b0;
        repeat (10) @(posedge m_clk);
        #1;
        m_rst = 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            kind = frame_kind(f);
            if (kind == KIND_BAD) begin
                len = 1 + {$random(seed)} % 8;
            end else if (kind == KIND_OVER) begin
                len = 17 + {$random(seed)} % (MAX_LEN - 16);
                // an empty memory keeps s_ready high through the drop
                wait_drained();
            end else begin
                len = (f < 16) ? f + 1 : 4 + {$random(seed)} % 13;
            end
            // heavy back-pressure so the memory fills up
            if (f == 30) begin
                ready_pct = 20;
            end
            send_frame(len, kind);
        end
        ready_pct = 100;
        wait_drained();
        assert (status_depth == '0 && status_depth_commit == '0)
            else report_failure("depth counts not zero after draining");
        assert (seen_good == exp_good) else report_failure("wrong number of good_frame pulses");
        assert (seen_bad == exp_bad) else report_failure("wrong number of bad_frame pulses");
        assert (seen_over == exp_over) else report_failure("wrong number of overflow pulses");
        assert (stall_cycles > 0) else report_failure("input never stalled on a full memory");
        if (frame_fifo_i.chk_i.failures == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            report_failure("a checker assertion failed");
        end
    end

endmodule

`default_nettype wire

//--- frame_fifo_wr_ctrl.sv
// frame FIFO write control that stores beats and commits, drops or rewinds whole frames

`default_nettype none

`include "frame_fifo_defines.svh"

module frame_fifo_wr_ctrl
    import frame_fifo_pkg::*;
(
    input  wire logic          m_clk,
    input  wire logic          m_rst,

    // input stream
    input  wire logic          s_valid,
    input  wire beat_t         s_beat,
    output logic               s_ready,

    // read pointer from the read pipeline for full detection
    input  wire ptr_t          rd_ptr,

    // memory write port
    output logic               wr_en,
    output addr_t              wr_addr,
    output beat_t              wr_beat,

    // end of the last committed frame
    output ptr_t               commit_ptr,

    output frame_status_t      status,
    output depth_t             status_depth,
    output depth_t             status_depth_commit
);

    wr_state_e     state;
    ptr_t          wr_ptr;
    ptr_t          wr_ptr_inc;
    ptr_t          commit_ptr_q;
    frame_status_t status_q;
    depth_t        depth_q;
    depth_t        depth_commit_q;
    logic          active;

    logic full;
    logic oversize;
    logic bad_user;
    logic accept;
    logic dropping;

    // same address with opposite wrap bit means the memory holds FF_DEPTH entries
    assign full = wr_ptr == {~rd_ptr[`FF_AW], rd_ptr[`FF_AW-1:0]};

    // current frame already fills the whole memory on its own
    assign oversize = wr_ptr == {~commit_ptr_q[`FF_AW], commit_ptr_q[`FF_AW-1:0]};

    assign bad_user = s_beat.user == user_t'(`FF_USER_BAD);
    assign wr_ptr_inc = wr_ptr + ptr_t'(1);

    // beats of an oversize frame are taken and thrown away
    assign dropping = (state == WR_DROP) || oversize;

    assign s_ready = active && (!full || dropping);
    assign accept = s_valid && s_ready;

    assign wr_en = accept && !dropping;
    assign wr_addr = wr_ptr[`FF_AW-1:0];
    assign wr_beat = s_beat;

    assign commit_ptr = commit_ptr_q;
    assign status = status_q;
    assign status_depth = depth_q;
    assign status_depth_commit = depth_commit_q;

    always_ff @(posedge m_clk or posedge m_rst) begin
        if (m_rst) begin
            active <= 1'b0;
            state <= WR_IDLE;
            wr_ptr <= '0;
            commit_ptr_q <= '0;
            status_q <= '0;
        end else begin
            active <= 1'b1;
            status_q <= '0;

            if (accept) begin
                if (dropping) begin
                    if (s_beat.last) begin
                        // give back the space taken by the partial frame
                        wr_ptr <= commit_ptr_q;
                        state <= WR_IDLE;
                        status_q.overflow <= 1'b1;
                    end else begin
                        state <= WR_DROP;
                    end
                end else if (s_beat.last) begin
                    state <= WR_IDLE;
                    if (bad_user) begin
                        wr_ptr <= commit_ptr_q;
                        status_q.bad_frame <= 1'b1;
                    end else begin
                        // frame becomes visible to the read side
                        wr_ptr <= wr_ptr_inc;
                        commit_ptr_q <= wr_ptr_inc;
                        status_q.good_frame <= 1'b1;
                    end
                end else begin
                    wr_ptr <= wr_ptr_inc;
                    state <= WR_FRAME;
                end
            end
        end
    end

    // fill level lags the pointers by one cycle
    always_ff @(posedge m_clk or posedge m_rst) begin
        if (m_rst) begin
            depth_q <= '0;
            depth_commit_q <= '0;
        end else begin
            depth_q <= depth_t'(wr_ptr - rd_ptr);
            depth_commit_q <= depth_t'(commit_ptr_q - rd_ptr);
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the frame FIFO testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module frame_fifo_tb -o frame_fifo_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/frame_fifo_sim +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
exit 0
